//--- Makefile
SIM := obj_dir/Vtb_issue_scoreboard
SRC := $(filter-out +%,$(shell cat build.f)) sb_consts.svh tb_sb_model.svh

.PHONY: all run clean

all: run

$(SIM): build.f $(SRC)
	verilator --binary --timing --assert -f build.f \
		--top-module tb_issue_scoreboard -o Vtb_issue_scoreboard

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+.
sb_pkg.sv
dispatch_decoder.sv
op_tracker.sv
issue_arbiter.sv
issue_scoreboard.sv
tb_issue_scoreboard.sv

//--- dispatch_decoder.sv
`timescale 1ns/100ps

`include "sb_consts.svh"

module dispatch_decoder (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      stall_i,
    input  logic                      issue_i,
    input  sb_pkg::dispatch_t         dispatch_i,
    output sb_pkg::delay_t            req_delay_o,
    output logic [`SB_MUL_DELAY-1:0]  mul_load_o,
    output logic                      div_load_o
);

    import sb_pkg::*;

    localparam int unsigned NUM_MUL = `SB_MUL_DELAY;

    unit_sel_t              unit;
    logic                   mul_fire;
    logic                   div_fire;
    logic [NUM_MUL-1:0]     mul_ptr_q;

    assign unit = dispatch_i.unit;

    // ==================================================
    // Requested writeback delay
    // ==================================================

    // One extra cycle for the bypass stage ahead of execution
    always_comb begin : req_delay_sel
        if (unit.mul) begin
            req_delay_o = delay_t'(`SB_MUL_DELAY + 1);
        end else if (unit.div) begin
            req_delay_o = delay_t'(`SB_DIV_DELAY + 1);
        end else if (unit.alu) begin
            req_delay_o = delay_t'(`SB_ALU_DELAY + 1);
        end else begin
            // Never matches a live countdown
            req_delay_o = '1;
        end
    end : req_delay_sel

    // Packet really enters execution on this edge
    assign mul_fire = issue_i & ~stall_i & unit.mul;
    assign div_fire = issue_i & ~stall_i & unit.div;

    // ==================================================
    // Multiplier stage pointer
    // ==================================================

    // One-hot pointer rotating once per issued multiply
    always_ff @(posedge clk_i) begin : mul_ptr_reg
        if (!rst_n_i) begin
            mul_ptr_q <= NUM_MUL'(1);
        end else if (flush_i) begin
            mul_ptr_q <= NUM_MUL'(1);
        end else if (mul_fire) begin
            mul_ptr_q <= {mul_ptr_q[NUM_MUL-2:0], mul_ptr_q[NUM_MUL-1]};
        end
    end : mul_ptr_reg

    // Load strobes toward the trackers
    assign mul_load_o = mul_ptr_q & {NUM_MUL{mul_fire}};
    assign div_load_o = div_fire;

    // Decode holds an offered packet until it is issued
    a_pkt_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (|unit && !(issue_i && !stall_i)) |=> $stable(dispatch_i)
    );

    // Decode never offers two units at once
    a_unit_onehot0: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(unit)
    );

endmodule : dispatch_decoder

//--- issue_arbiter.sv
`timescale 1ns/100ps

`include "sb_consts.svh"

module issue_arbiter (
    input  sb_pkg::dispatch_t                           dispatch_i,
    input  sb_pkg::track_status_t [`SB_MUL_DELAY-1:0]   mul_status_i,
    input  sb_pkg::track_status_t                       div_status_i,
    output logic                                        issue_o,
    output logic                                        pipeline_empty_o
);

    import sb_pkg::*;

    track_status_t  any_status;
    logic           raw_hazard;
    logic           wb_hazard;
    logic           struct_hazard;

    // ==================================================
    // Status reduction
    // ==================================================

    // Field-wise OR over every tracker
    always_comb begin : status_or
        any_status = div_status_i;
        for (int i = 0; i < `SB_MUL_DELAY; i++) begin
            any_status = any_status | mul_status_i[i];
        end
    end : status_or

    assign raw_hazard = any_status.raw_hit;
    assign wb_hazard  = any_status.wb_hit;

    // Divider takes a single operation at a time
    assign struct_hazard = dispatch_i.unit.div & div_status_i.busy;

    // ==================================================
    // Outputs
    // ==================================================

    // Grant only with no hazard of any kind
    assign issue_o = ~(raw_hazard | wb_hazard | struct_hazard);

    // Nothing left in flight
    assign pipeline_empty_o = ~any_status.busy;

endmodule : issue_arbiter

//--- issue_scoreboard.sv
`timescale 1ns/100ps

`include "sb_consts.svh"

module issue_scoreboard (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  sb_pkg::dispatch_t   dispatch_i,
    output logic                issue_o,
    output logic                pipeline_empty_o
);

    import sb_pkg::*;

    delay_t                             req_delay;
    logic [`SB_MUL_DELAY-1:0]           mul_load;
    logic                               div_load;
    track_status_t [`SB_MUL_DELAY-1:0]  mul_status;
    track_status_t                      div_status;

    // ==================================================
    // Decode and stage selection
    // ==================================================

    dispatch_decoder u_decoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .issue_i     (issue_o),
        .dispatch_i  (dispatch_i),
        .req_delay_o (req_delay),
        .mul_load_o  (mul_load),
        .div_load_o  (div_load)
    );

    // ==================================================
    // Trackers
    // ==================================================

    // One tracker per multiplier pipeline stage
    for (genvar g = 0; g < `SB_MUL_DELAY; g++) begin : g_mul_trk
        op_tracker #(
            .MAX_DELAY (`SB_MUL_DELAY)
        ) u_mul_trk (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .stall_i     (stall_i),
            .load_i      (mul_load[g]),
            .dispatch_i  (dispatch_i),
            .req_delay_i (req_delay),
            .status_o    (mul_status[g])
        );
    end : g_mul_trk

    // Sequential divider needs only one
    op_tracker #(
        .MAX_DELAY (`SB_DIV_DELAY)
    ) u_div_trk (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .load_i      (div_load),
        .dispatch_i  (dispatch_i),
        .req_delay_i (req_delay),
        .status_o    (div_status)
    );

    // Final issue decision
    issue_arbiter u_arbiter (
        .dispatch_i       (dispatch_i),
        .mul_status_i     (mul_status),
        .div_status_i     (div_status),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

endmodule : issue_scoreboard

//--- op_tracker.sv
`timescale 1ns/100ps

`include "sb_consts.svh"

module op_tracker #(
    // Cycles the unit needs to write back
    parameter int unsigned MAX_DELAY = `SB_MUL_DELAY
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    stall_i,
    input  logic                    load_i,
    input  sb_pkg::dispatch_t       dispatch_i,
    input  sb_pkg::delay_t          req_delay_i,
    output sb_pkg::track_status_t   status_o
);

    import sb_pkg::*;

    localparam delay_t LOAD_VAL = delay_t'(MAX_DELAY);

    delay_t     cnt_q;
    reg_addr_t  dest_q;
    logic       busy;
    logic       src_match;

    // ==================================================
    // Countdown
    // ==================================================

    // Flush drops the operation even on a load edge
    always_ff @(posedge clk_i) begin : countdown_reg
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;
        end else if (!stall_i) begin
            if (load_i) begin
                cnt_q <= LOAD_VAL;
            end else if (busy) begin
                // One step closer to writeback
                cnt_q <= cnt_q - delay_t'(1);
            end
        end
    end : countdown_reg

    // Destination of the operation in flight
    always_ff @(posedge clk_i) begin : dest_reg
        if (load_i && !stall_i) begin
            dest_q <= dispatch_i.dest;
        end
    end : dest_reg

    assign busy = (cnt_q != '0);

    // ==================================================
    // Hazard compares
    // ==================================================

    // Sources cover RAW and dest covers WAW
    assign src_match = (dispatch_i.src0 == dest_q)
                     | (dispatch_i.src1 == dest_q)
                     | (dispatch_i.dest == dest_q);

    always_comb begin : status_pack
        status_o.busy    = busy;
        // Register zero is hardwired and never tracked
        status_o.raw_hit = busy & (dest_q != '0) & src_match;
        // New op would write back in the same cycle as this one
        status_o.wb_hit  = busy & (cnt_q == req_delay_i);
    end : status_pack

    // Reload only once the previous operation is at most one cycle from writeback
    a_reload_free: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        load_i |-> (cnt_q <= delay_t'(1))
    );

endmodule : op_tracker

//--- sb_consts.svh
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// Register file addressing
`define SB_REG_ADDR_W 5

// ==================================================
// Writeback delays of the execution units
// ==================================================

// Single cycle ALU with CSR operations
`define SB_ALU_DELAY 1

// Pipelined multiplier, one tracker per stage
`define SB_MUL_DELAY 6

// Sequential divider
`define SB_DIV_DELAY 36

// Countdown width, must hold SB_DIV_DELAY + 1
`define SB_CNT_W 6

`endif

//--- sb_pkg.sv
`include "sb_consts.svh"

package sb_pkg;

    // Architectural register address
    typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

    // Writeback delay or tracker countdown
    typedef logic [`SB_CNT_W-1:0] delay_t;

    // Target unit of a dispatch packet
    // At most one bit set, none set means nothing offered
    typedef struct packed {
        logic alu;
        logic mul;
        logic div;
    } unit_sel_t;

    // ==================================================
    // Dispatch packet from decode
    // ==================================================

    typedef struct packed {
        reg_addr_t src0;
        reg_addr_t src1;
        reg_addr_t dest;
        unit_sel_t unit;
    } dispatch_t;

    // ==================================================
    // Per tracker status
    // ==================================================

    // busy    : countdown still running
    // raw_hit : register dependency on the offered packet
    // wb_hit  : writeback slot already taken
    typedef struct packed {
        logic busy;
        logic raw_hit;
        logic wb_hit;
    } track_status_t;

endpackage : sb_pkg

//--- tb_sb_model.svh
`ifndef TB_SB_MODEL_SVH
`define TB_SB_MODEL_SVH

`include "sb_consts.svh"

// ==================================================
// Reference model of the operations in flight
// ==================================================

// Cycles left and destination per multiplier slot
int unsigned m_mul_cnt  [`SB_MUL_DELAY];
reg_addr_t   m_mul_dest [`SB_MUL_DELAY];
// Slot that takes the next multiply
int unsigned m_mul_slot;
// Divider has a single slot
int unsigned m_div_cnt;
reg_addr_t   m_div_dest;

function automatic void reset_model();
    for (int i = 0; i < `SB_MUL_DELAY; i++) begin
        m_mul_cnt[i]  = 0;
        m_mul_dest[i] = '0;
    end
    m_mul_slot = 0;
    m_div_cnt  = 0;
    m_div_dest = '0;
endfunction

// Writeback delay asked for by the packet
// Zero when nothing is offered, so it never meets a live slot
function automatic int unsigned requested_delay(dispatch_t pkt);
    int unsigned delay;
    delay = 0;
    if (pkt.unit.mul) begin
        delay = `SB_MUL_DELAY + 1;
    end else if (pkt.unit.div) begin
        delay = `SB_DIV_DELAY + 1;
    end else if (pkt.unit.alu) begin
        delay = `SB_ALU_DELAY + 1;
    end
    return delay;
endfunction

// One live slot against the offered packet
function automatic bit slot_blocks(int unsigned cnt, reg_addr_t dest, dispatch_t pkt);
    bit dep;
    bit wb;
    // x0 never creates a dependency
    dep = (dest != '0) && ((pkt.src0 == dest) || (pkt.src1 == dest) || (pkt.dest == dest));
    wb  = (cnt == requested_delay(pkt));
    return (cnt != 0) && (dep || wb);
endfunction

function automatic bit predict_issue(dispatch_t pkt);
    bit blocked;
    // Divider accepts one operation at a time
    blocked = (pkt.unit.div && (m_div_cnt != 0)) || slot_blocks(m_div_cnt, m_div_dest, pkt);
    for (int i = 0; i < `SB_MUL_DELAY; i++) begin
        blocked = blocked || slot_blocks(m_mul_cnt[i], m_mul_dest[i], pkt);
    end
    return !blocked;
endfunction

function automatic bit predict_empty();
    bit empty;
    empty = (m_div_cnt == 0);
    for (int i = 0; i < `SB_MUL_DELAY; i++) begin
        empty = empty && (m_mul_cnt[i] == 0);
    end
    return empty;
endfunction

// Advance by one rising edge
function automatic void step_model(dispatch_t pkt, bit stall, bit flush, bit issued);
    if (flush) begin
        for (int i = 0; i < `SB_MUL_DELAY; i++) begin
            m_mul_cnt[i] = 0;
        end
        m_div_cnt  = 0;
        m_mul_slot = 0;
    end else if (!stall) begin
        for (int i = 0; i < `SB_MUL_DELAY; i++) begin
            if (m_mul_cnt[i] != 0) begin
                m_mul_cnt[i] = m_mul_cnt[i] - 1;
            end
        end
        if (m_div_cnt != 0) begin
            m_div_cnt = m_div_cnt - 1;
        end
        // New operation lands after the others moved on
        if (issued && pkt.unit.mul) begin
            m_mul_cnt[m_mul_slot]  = `SB_MUL_DELAY;
            m_mul_dest[m_mul_slot] = pkt.dest;
            m_mul_slot = (m_mul_slot + 1) % `SB_MUL_DELAY;
        end
        if (issued && pkt.unit.div) begin
            m_div_cnt  = `SB_DIV_DELAY;
            m_div_dest = pkt.dest;
        end
    end
endfunction

`endif

//--- tb_issue_scoreboard.sv
`timescale 1ns/100ps

`include "sb_consts.svh"

module tb_issue_scoreboard;

    import sb_pkg::*;

    `include "tb_sb_model.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    // Per test cycle budget in test order
    localparam int TEST_CYCLES  = 10 + 25 + 20 + 80 + 20 + 25;
    // Stall window inside the stall test
    localparam int STALL_FIRST  = 3;
    localparam int STALL_CYCLES = 3;

    localparam unit_sel_t U_NONE = '{alu: 1'b0, mul: 1'b0, div: 1'b0};
    localparam unit_sel_t U_ALU  = '{alu: 1'b1, mul: 1'b0, div: 1'b0};
    localparam unit_sel_t U_MUL  = '{alu: 1'b0, mul: 1'b1, div: 1'b0};
    localparam unit_sel_t U_DIV  = '{alu: 1'b0, mul: 1'b0, div: 1'b1};

    logic       clk_i;
    logic       rst_n_i;
    logic       flush_i;
    logic       stall_i;
    dispatch_t  dispatch_i;
    logic       issue_o;
    logic       pipeline_empty_o;

    integer     seed = 32'hf18be36a;
    string      test_name;
    int         test_errors;
    int         total_errors;
    int         tests_run;
    int         tests_failed;

    issue_scoreboard DUT (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .dispatch_i       (dispatch_i),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic dispatch_t make_pkt(reg_addr_t s0, reg_addr_t s1, reg_addr_t d,
                                           unit_sel_t u);
        dispatch_t pkt;
        pkt.src0 = s0;
        pkt.src1 = s1;
        pkt.dest = d;
        pkt.unit = u;
        return pkt;
    endfunction

    // Random nonzero register
    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(($unsigned($random(seed)) % 31) + 1);
    endfunction

    // A nonzero register other than r
    function automatic reg_addr_t next_reg(reg_addr_t r);
        return reg_addr_t'((int'(r) % 31) + 1);
    endfunction

    task automatic report_mismatch(input string what, input string exp, input string act);
        $display("** Error [%s] %s: expected %s, actual %s", test_name, what, exp, act);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("Test %-14s failed, %0d errors", test_name, test_errors);
        end else begin
            $display("Test %-14s ok", test_name);
        end
    endtask

    // Drive one cycle, compare with the model mid cycle and advance
    task automatic drive_cycle(input dispatch_t pkt, input bit stall, input bit flush,
                               output bit granted);
        bit exp_issue;
        bit exp_empty;
        dispatch_i = pkt;
        stall_i    = stall;
        flush_i    = flush;
        exp_issue  = predict_issue(pkt);
        exp_empty  = predict_empty();
        @(negedge clk_i);
        if (issue_o !== exp_issue) begin
            report_mismatch("issue_o", $sformatf("%b", exp_issue), $sformatf("%b", issue_o));
        end
        if (pipeline_empty_o !== exp_empty) begin
            report_mismatch("pipeline_empty_o", $sformatf("%b", exp_empty),
                            $sformatf("%b", pipeline_empty_o));
        end
        granted = (issue_o === 1'b1) && (|pkt.unit) && !stall;
        @(posedge clk_i);
        step_model(pkt, stall, flush, exp_issue && (|pkt.unit) && !stall);
        #(DRIVE_DELAY);
    endtask

    // Packet must go through in this very cycle
    task automatic issue_now(input dispatch_t pkt);
        bit granted;
        drive_cycle(pkt, 1'b0, 1'b0, granted);
        if (!granted) begin
            report_mismatch("immediate issue", "1", "0");
        end
    endtask

    // Hold a packet until it issues and count the blocked cycles
    task automatic offer_until_grant(input dispatch_t pkt, input int max_wait, output int waited);
        bit granted;
        granted = 1'b0;
        waited  = 0;
        while (!granted && waited <= max_wait) begin
            drive_cycle(pkt, 1'b0, 1'b0, granted);
            if (!granted) begin
                waited++;
            end
        end
        if (!granted) begin
            $display("[%s] packet still not issued after %0d cycles", test_name, max_wait);
            test_errors++;
        end
    endtask

    // Idle cycles until nothing is in flight
    task automatic drain_pipeline(input int max_wait, output int cycles);
        bit granted;
        cycles = 0;
        while (pipeline_empty_o !== 1'b1 && cycles < max_wait) begin
            drive_cycle(make_pkt('0, '0, '0, U_NONE), 1'b0, 1'b0, granted);
            cycles++;
        end
        if (pipeline_empty_o !== 1'b1) begin
            $display("[%s] pipeline still busy after %0d cycles", test_name, max_wait);
            test_errors++;
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_after_reset();
        bit granted;
        start_test("after_reset");
        if (pipeline_empty_o !== 1'b1) begin
            report_mismatch("pipeline_empty_o", "1", $sformatf("%b", pipeline_empty_o));
        end
        // Empty packet still sees a high grant
        drive_cycle(make_pkt('0, '0, '0, U_NONE), 1'b0, 1'b0, granted);
        // ALU results are never tracked
        for (int k = 0; k < 4; k++) begin
            issue_now(make_pkt(rand_reg(), rand_reg(), rand_reg(), U_ALU));
        end
        drive_cycle(make_pkt('0, '0, '0, U_NONE), 1'b0, 1'b0, granted);
        finish_test();
    endtask

    task automatic test_mul_raw();
        reg_addr_t r;
        int        waited;
        int        cycles;
        start_test("mul_raw");
        r = rand_reg();
        issue_now(make_pkt('0, '0, r, U_MUL));
        offer_until_grant(make_pkt(r, next_reg(r), next_reg(r), U_ALU), 20, waited);
        if (waited != `SB_MUL_DELAY) begin
            report_mismatch("blocked cycles", $sformatf("%0d", `SB_MUL_DELAY),
                            $sformatf("%0d", waited));
        end
        // Same sequence through x0
        issue_now(make_pkt('0, '0, '0, U_MUL));
        offer_until_grant(make_pkt('0, '0, rand_reg(), U_ALU), 20, waited);
        if (waited != 0) begin
            report_mismatch("blocked cycles on x0", "0", $sformatf("%0d", waited));
        end
        drain_pipeline(20, cycles);
        finish_test();
    endtask

    task automatic test_mul_pipeline();
        int unsigned base;
        int          cycles;
        start_test("mul_pipeline");
        base = $unsigned($random(seed)) % 31;
        // Distinct destinations with x0 sources
        for (int unsigned i = 0; i < `SB_MUL_DELAY; i++) begin
            issue_now(make_pkt('0, '0, reg_addr_t'(((base + i) % 31) + 1), U_MUL));
        end
        if (pipeline_empty_o !== 1'b0) begin
            report_mismatch("pipeline_empty_o", "0", $sformatf("%b", pipeline_empty_o));
        end
        // Last multiply stays busy for the full latency
        drain_pipeline(20, cycles);
        if (cycles != `SB_MUL_DELAY) begin
            report_mismatch("drain cycles", $sformatf("%0d", `SB_MUL_DELAY),
                            $sformatf("%0d", cycles));
        end
        finish_test();
    endtask

    task automatic test_div_struct();
        reg_addr_t r;
        int        waited;
        int        cycles;
        start_test("div_struct");
        r = rand_reg();
        issue_now(make_pkt('0, '0, r, U_DIV));
        offer_until_grant(make_pkt('0, '0, next_reg(r), U_DIV), 50, waited);
        if (waited != `SB_DIV_DELAY) begin
            report_mismatch("blocked cycles", $sformatf("%0d", `SB_DIV_DELAY),
                            $sformatf("%0d", waited));
        end
        drain_pipeline(50, cycles);
        if (cycles != `SB_DIV_DELAY) begin
            report_mismatch("drain cycles", $sformatf("%0d", `SB_DIV_DELAY),
                            $sformatf("%0d", cycles));
        end
        finish_test();
    endtask

    task automatic test_wb_collision();
        reg_addr_t r;
        dispatch_t other;
        bit        granted;
        int        hit_cycle;
        start_test("wb_collision");
        r     = rand_reg();
        other = make_pkt(next_reg(r), next_reg(next_reg(r)), next_reg(r), U_ALU);
        // Countdown in cycle k after issue is MUL - k + 1 and ALU asks for ALU + 1
        hit_cycle = `SB_MUL_DELAY - `SB_ALU_DELAY;
        issue_now(make_pkt('0, '0, r, U_MUL));
        for (int k = 1; k <= `SB_MUL_DELAY + 2; k++) begin
            drive_cycle(other, 1'b0, 1'b0, granted);
            if (granted == (k == hit_cycle)) begin
                report_mismatch($sformatf("issue in cycle %0d", k),
                                $sformatf("%b", k != hit_cycle), $sformatf("%b", granted));
            end
        end
        finish_test();
    endtask

    task automatic test_stall_flush();
        reg_addr_t r;
        dispatch_t dep;
        bit        granted;
        bit        stalled;
        int        k;
        start_test("stall_flush");
        r   = rand_reg();
        dep = make_pkt(r, '0, next_reg(r), U_ALU);
        issue_now(make_pkt('0, '0, r, U_MUL));
        granted = 1'b0;
        k       = 0;
        while (!granted && k < 30) begin
            k++;
            stalled = (k >= STALL_FIRST) && (k < STALL_FIRST + STALL_CYCLES);
            drive_cycle(dep, stalled, 1'b0, granted);
        end
        // Every stalled cycle adds one to the wait
        if (!granted) begin
            $display("[%s] dependent packet never issued around the stall", test_name);
            test_errors++;
        end else if (k - 1 != `SB_MUL_DELAY + STALL_CYCLES) begin
            report_mismatch("blocked cycles", $sformatf("%0d", `SB_MUL_DELAY + STALL_CYCLES),
                            $sformatf("%0d", k - 1));
        end
        // Flush drops the multiply under the dependent packet
        r   = rand_reg();
        dep = make_pkt(next_reg(r), r, '0, U_ALU);
        issue_now(make_pkt('0, '0, r, U_MUL));
        repeat (2) begin
            drive_cycle(dep, 1'b0, 1'b0, granted);
        end
        drive_cycle(dep, 1'b0, 1'b1, granted);
        if (pipeline_empty_o !== 1'b1) begin
            report_mismatch("pipeline_empty_o after flush", "1",
                            $sformatf("%b", pipeline_empty_o));
        end
        issue_now(dep);
        finish_test();
    endtask

    // ==================================================
    // Sequence and watchdog
    // ==================================================

    initial begin : main_seq
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        dispatch_i   = '0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_n_i = 1'b1;
        test_after_reset();
        test_mul_raw();
        test_mul_pipeline();
        test_div_struct();
        test_wb_collision();
        test_stall_flush();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end : main_seq

    // Twice the summed budget of reset and tests
    initial begin : watchdog
        #(2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, test %s did not finish in time", test_name);
        $display("TB FAILED");
        $finish;
    end : watchdog

endmodule : tb_issue_scoreboard
